/* verilog/vip_pkg.sv */
`default_nettype none

package vip_pkg;

	// ----------------------------------------------------------------------
	// raster geometry
	// ----------------------------------------------------------------------

	// active window, kept small so one frame simulates quickly
	localparam int img_hdisp = 16;
	localparam int img_vdisp = 8;

	// horizontal slots, one slot is two clocks
	localparam int h_sync  = 5;
	localparam int h_back  = 5;
	localparam int h_front = 5;
	localparam int h_total = h_sync + h_back + img_hdisp + h_front;

	// vertical lines
	localparam int v_sync  = 1;
	localparam int v_back  = 0;
	localparam int v_front = 1;
	localparam int v_total = v_sync + v_back + img_vdisp + v_front;

	// first active slot and line
	localparam int h_start = h_sync + h_back;
	localparam int v_start = v_sync + v_back;

	// clocks per frame, pixel enable runs at half rate
	localparam int frame_cycles = h_total * v_total * 2;

	// ----------------------------------------------------------------------
	// pixel and bus types
	// ----------------------------------------------------------------------

	// red in the top byte, blue in the bottom byte
	typedef logic [23:0] pix_t;
	typedef logic [7:0]  coord_t;
	typedef logic [6:0]  addr_t;

	// box border colour
	localparam pix_t overlay_rgb = 24'h00_00_ff;

	// register index for the box block
	typedef enum logic [2:0] {
		sel_up    = 3'd0,
		sel_down  = 3'd1,
		sel_left  = 3'd2,
		sel_right = 3'd3,
		sel_ctrl  = 3'd4
	} box_sel_t;

endpackage

`default_nettype wire

/* verilog/cmos_timing_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module cmos_timing_gen (
	input  logic            clk,
	input  logic            rst_n,
	output logic            vsync,
	output logic            href,
	output logic            pix_en,
	output vip_pkg::addr_t  rd_addr,
	output vip_pkg::coord_t x_pos,
	output vip_pkg::coord_t y_pos
);

	logic            clken_r;
	vip_pkg::coord_t hcnt;
	vip_pkg::coord_t vcnt;
	logic            active;
	logic            href_r;
	vip_pkg::coord_t x_act;
	vip_pkg::coord_t y_act;

	// ----------------------------------------------------------------------
	// half-rate pixel enable, like a camera pclk
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			clken_r <= 1'b0;
		else
			clken_r <= ~clken_r;
	end

	// horizontal slot counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hcnt <= '0;
		end else if (clken_r) begin
			if (hcnt == vip_pkg::coord_t'(vip_pkg::h_total - 1))
				hcnt <= '0;
			else
				hcnt <= hcnt + 8'd1;
		end
	end

	// line counter, steps at end of line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vcnt <= '0;
		end else if (clken_r && hcnt == vip_pkg::coord_t'(vip_pkg::h_total - 1)) begin
			if (vcnt == vip_pkg::coord_t'(vip_pkg::v_total - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 8'd1;
		end
	end

	// ----------------------------------------------------------------------
	// sync levels
	// ----------------------------------------------------------------------

	// low on the sync line only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vsync <= 1'b0;
		else
			vsync <= (vcnt >= vip_pkg::v_sync);
	end

	// display window, one cycle ahead of the address
	assign active = (vcnt >= vip_pkg::v_start)
		&& (vcnt < vip_pkg::v_start + vip_pkg::img_vdisp)
		&& (hcnt >= vip_pkg::h_start)
		&& (hcnt < vip_pkg::h_start + vip_pkg::img_hdisp);

	// href two clocks behind active
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			href_r <= 1'b0;
			href   <= 1'b0;
		end else begin
			href_r <= active;
			href   <= href_r;
		end
	end

	// one strobe per slot
	assign pix_en = href & clken_r;

	// ----------------------------------------------------------------------
	// raster position to linear address
	// ----------------------------------------------------------------------
	assign x_act = active ? vip_pkg::coord_t'(hcnt - vip_pkg::h_start) : '0;
	assign y_act = active ? vip_pkg::coord_t'(vcnt - vip_pkg::v_start) : '0;

	// coordinates stay aligned with the address
	always_ff @(posedge clk) begin
		rd_addr <= vip_pkg::addr_t'(y_act * vip_pkg::img_hdisp + x_act);
		x_pos   <= x_act;
		y_pos   <= y_act;
	end

endmodule

`default_nettype wire

/* verilog/plate_box_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module plate_box_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cfg_we,
	input  vip_pkg::box_sel_t cfg_sel,
	input  vip_pkg::coord_t   cfg_wdata,
	output vip_pkg::coord_t   box_up,
	output vip_pkg::coord_t   box_down,
	output vip_pkg::coord_t   box_left,
	output vip_pkg::coord_t   box_right,
	output logic              overlay_en
);

	// ----------------------------------------------------------------------
	// box edges and control, written by software
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			box_up     <= '0;
			box_down   <= '0;
			box_left   <= '0;
			box_right  <= '0;
			overlay_en <= 1'b0;
		end else if (cfg_we) begin
			case (cfg_sel)
				vip_pkg::sel_up:
					box_up <= cfg_wdata;
				vip_pkg::sel_down:
					box_down <= cfg_wdata;
				vip_pkg::sel_left:
					box_left <= cfg_wdata;
				vip_pkg::sel_right:
					box_right <= cfg_wdata;
				// bit 0 enables the outline
				vip_pkg::sel_ctrl:
					overlay_en <= cfg_wdata[0];
				// unmapped index, write dropped
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/box_overlay.sv */
`timescale 1ns/100ps
`default_nettype none

module box_overlay (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            vsync_in,
	input  logic            pix_en_in,
	input  vip_pkg::coord_t x_in,
	input  vip_pkg::coord_t y_in,
	input  vip_pkg::pix_t   rd_data,
	input  vip_pkg::coord_t box_up,
	input  vip_pkg::coord_t box_down,
	input  vip_pkg::coord_t box_left,
	input  vip_pkg::coord_t box_right,
	input  logic            overlay_en,
	output logic            vsync_out,
	output logic            pix_en_out,
	output vip_pkg::pix_t   pix_out
);

	vip_pkg::coord_t x_d;
	vip_pkg::coord_t y_d;
	vip_pkg::pix_t   data_r;
	logic            on_col;
	logic            on_row;

	// ----------------------------------------------------------------------
	// fetch stage, memory word lands with href
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		x_d    <= x_in;
		y_d    <= y_in;
		data_r <= rd_data;
	end

	// left or right edge within the vertical span
	assign on_col = ((x_d == box_left) || (x_d == box_right))
		&& (y_d >= box_up) && (y_d <= box_down);

	// top or bottom edge within the horizontal span
	assign on_row = ((y_d == box_up) || (y_d == box_down))
		&& (x_d >= box_left) && (x_d <= box_right);

	// ----------------------------------------------------------------------
	// output stage
	// ----------------------------------------------------------------------

	// strobes follow the pixel by one clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vsync_out  <= 1'b0;
			pix_en_out <= 1'b0;
		end else begin
			vsync_out  <= vsync_in;
			pix_en_out <= pix_en_in;
		end
	end

	// blue on the outline, source word elsewhere
	always_ff @(posedge clk) begin
		if (overlay_en && (on_col || on_row))
			pix_out <= vip_pkg::overlay_rgb;
		else
			pix_out <= data_r;
	end

endmodule

`default_nettype wire

/* verilog/frame_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_capture (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           capture_start,
	input  logic           vsync,
	input  logic           pix_en,
	input  vip_pkg::pix_t  pix,
	output logic           cap_we,
	output vip_pkg::addr_t cap_addr,
	output vip_pkg::pix_t  cap_data,
	output logic           frame_done
);

	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_armed = 2'd1,
		st_cap   = 2'd2
	} cap_state_t;

	cap_state_t     state;
	logic           vsync_d;
	logic           vs_rise;
	logic           vs_fall;
	vip_pkg::addr_t addr_cnt;

	// ----------------------------------------------------------------------
	// frame edges
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vsync_d <= 1'b0;
		else
			vsync_d <= vsync;
	end

	assign vs_rise = vsync & ~vsync_d;
	assign vs_fall = ~vsync & vsync_d;

	// ----------------------------------------------------------------------
	// arm, capture one frame, back to idle
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			frame_done <= 1'b0;
			addr_cnt   <= '0;
			cap_addr   <= '0;
			cap_we     <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			cap_we     <= 1'b0;
			case (state)
				st_idle: begin
					if (capture_start)
						state <= st_armed;
				end
				// wait for a clean frame start
				st_armed: begin
					if (vs_rise) begin
						state    <= st_cap;
						addr_cnt <= '0;
					end
				end
				st_cap: begin
					if (vs_fall) begin
						state      <= st_idle;
						frame_done <= 1'b1;
					end else if (pix_en) begin
						cap_we   <= 1'b1;
						cap_addr <= addr_cnt;
						addr_cnt <= addr_cnt + 7'd1;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// write data rides with the strobe
	always_ff @(posedge clk) begin
		if (state == st_cap && pix_en)
			cap_data <= pix;
	end

endmodule

`default_nettype wire

/* verilog/cam_replay_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cam_replay_top (
	input  logic              clk,
	input  logic              rst_n,
	output vip_pkg::addr_t    rd_addr,
	input  vip_pkg::pix_t     rd_data,
	input  logic              cfg_we,
	input  vip_pkg::box_sel_t cfg_sel,
	input  vip_pkg::coord_t   cfg_wdata,
	input  logic              capture_start,
	output logic              cap_we,
	output vip_pkg::addr_t    cap_addr,
	output vip_pkg::pix_t     cap_data,
	output logic              frame_done,
	output logic              vsync,
	output logic              href
);

	logic            gen_pix_en;
	vip_pkg::coord_t x_pos;
	vip_pkg::coord_t y_pos;
	vip_pkg::coord_t box_up;
	vip_pkg::coord_t box_down;
	vip_pkg::coord_t box_left;
	vip_pkg::coord_t box_right;
	logic            overlay_en;
	logic            ov_vsync;
	logic            ov_pix_en;
	vip_pkg::pix_t   ov_pix;

	// ----------------------------------------------------------------------
	// camera replay
	// ----------------------------------------------------------------------
	cmos_timing_gen u_timing (
		.clk     (clk),
		.rst_n   (rst_n),
		.vsync   (vsync),
		.href    (href),
		.pix_en  (gen_pix_en),
		.rd_addr (rd_addr),
		.x_pos   (x_pos),
		.y_pos   (y_pos)
	);

	// box registers
	plate_box_regs u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_we     (cfg_we),
		.cfg_sel    (cfg_sel),
		.cfg_wdata  (cfg_wdata),
		.box_up     (box_up),
		.box_down   (box_down),
		.box_left   (box_left),
		.box_right  (box_right),
		.overlay_en (overlay_en)
	);

	// outline painter
	box_overlay u_overlay (
		.clk        (clk),
		.rst_n      (rst_n),
		.vsync_in   (vsync),
		.pix_en_in  (gen_pix_en),
		.x_in       (x_pos),
		.y_in       (y_pos),
		.rd_data    (rd_data),
		.box_up     (box_up),
		.box_down   (box_down),
		.box_left   (box_left),
		.box_right  (box_right),
		.overlay_en (overlay_en),
		.vsync_out  (ov_vsync),
		.pix_en_out (ov_pix_en),
		.pix_out    (ov_pix)
	);

	// single-frame grab into the external store
	frame_capture u_capture (
		.clk           (clk),
		.rst_n         (rst_n),
		.capture_start (capture_start),
		.vsync         (ov_vsync),
		.pix_en        (ov_pix_en),
		.pix           (ov_pix),
		.cap_we        (cap_we),
		.cap_addr      (cap_addr),
		.cap_data      (cap_data),
		.frame_done    (frame_done)
	);

endmodule

`default_nettype wire

/* tb/cam_replay_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module cam_replay_chk (
	input logic clk,
	input logic rst_n,
	input logic vsync,
	input logic href,
	input logic pix_en
);

	// ----------------------------------------------------------------------
	// sync generator rules
	// ----------------------------------------------------------------------

	// never two strobes in a row, and strobes two clocks apart along a line
	pix_en_half_rate: assert property (@(posedge clk) disable iff (!rst_n)
		pix_en |=> !pix_en ##1 (pix_en || !href))
		else $error("pix_en not on a two clock cadence inside the line");

	// strobe inside a line on the second clock of its slot
	pix_en_in_line: assert property (@(posedge clk) disable iff (!rst_n)
		pix_en |-> href && $past(href))
		else $error("pix_en high without href on this and the previous clock");

	// no line during vertical sync
	href_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
		!vsync |-> !href)
		else $error("href high while vsync low");

endmodule

bind cmos_timing_gen cam_replay_chk u_chk (
	.clk    (clk),
	.rst_n  (rst_n),
	.vsync  (vsync),
	.href   (href),
	.pix_en (pix_en)
);

`default_nettype wire

/* tb/tb_cam_replay.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cam_replay;

	localparam int max_cases   = 8;
	localparam int case_fields = 5;
	localparam int n_pixels    = vip_pkg::img_hdisp * vip_pkg::img_vdisp;

	logic              clk;
	logic              rst_n;
	vip_pkg::addr_t    rd_addr;
	vip_pkg::pix_t     rd_data;
	logic              cfg_we;
	vip_pkg::box_sel_t cfg_sel;
	vip_pkg::coord_t   cfg_wdata;
	logic              capture_start;
	logic              cap_we;
	vip_pkg::addr_t    cap_addr;
	vip_pkg::pix_t     cap_data;
	logic              frame_done;
	logic              vsync;
	logic              href;

	// source image answering rd_addr without latency
	vip_pkg::pix_t   image_mem [0:n_pixels-1];
	// up down left right enable for each case
	vip_pkg::coord_t case_words [0:max_cases*case_fields-1];
	int              n_cases;
	int              cycle_count;
	int              cycle_limit;
	logic            capture_open;
	int unsigned     seed_val;

	// sync output bookkeeping
	logic            vsync_q;
	logic            href_q;
	logic            sync_locked;
	int              frame_len;
	int              vs_low_len;
	int              href_len;
	int              href_lines;
	int              frames_checked;

	cam_replay_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.cfg_we        (cfg_we),
		.cfg_sel       (cfg_sel),
		.cfg_wdata     (cfg_wdata),
		.capture_start (capture_start),
		.cap_we        (cap_we),
		.cap_addr      (cap_addr),
		.cap_data      (cap_data),
		.frame_done    (frame_done),
		.vsync         (vsync),
		.href          (href)
	);

	assign rd_data = image_mem[rd_addr];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// failure reporting and compare tasks
	// ----------------------------------------------------------------------
	task automatic end_failed;
		$display("ERRORS FOUND");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic stop_with(input string why);
		$display("error at %0t: %s", $time, why);
		end_failed();
	endtask

	task automatic check_addr(input string name, input vip_pkg::addr_t exp,
		input vip_pkg::addr_t act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
			end_failed();
		end
	endtask

	task automatic check_pix(input string name, input vip_pkg::pix_t exp,
		input vip_pkg::pix_t act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %06h got %06h", $time, name, exp, act);
			end_failed();
		end
	endtask

	// clock counts of the sync levels
	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
			end_failed();
		end
	endtask

	// outline rule on raster coordinates
	function automatic vip_pkg::pix_t expected_pixel(input int addr, input int up,
		input int down, input int left, input int right, input logic en);
		int x;
		int y;
		logic on_col;
		logic on_row;
		x = addr % vip_pkg::img_hdisp;
		y = addr / vip_pkg::img_hdisp;
		on_col = (x == left || x == right) && y >= up && y <= down;
		on_row = (y == up || y == down) && x >= left && x <= right;
		if (en && (on_col || on_row))
			return vip_pkg::overlay_rgb;
		return image_mem[addr];
	endfunction

	// ----------------------------------------------------------------------
	// stimulus driven on the falling edge
	// ----------------------------------------------------------------------
	task automatic write_reg(input vip_pkg::box_sel_t sel, input vip_pkg::coord_t val);
		@(negedge clk);
		cfg_we    = 1'b1;
		cfg_sel   = sel;
		cfg_wdata = val;
		@(negedge clk);
		cfg_we    = 1'b0;
	endtask

	// program the box, grab one frame, compare every write
	task automatic run_case(input int idx);
		int up;
		int down;
		int left;
		int right;
		logic en;
		int n_writes;
		logic got_done;
		up    = case_words[idx*case_fields];
		down  = case_words[idx*case_fields+1];
		left  = case_words[idx*case_fields+2];
		right = case_words[idx*case_fields+3];
		en    = case_words[idx*case_fields+4][0];
		write_reg(vip_pkg::sel_up, vip_pkg::coord_t'(up));
		write_reg(vip_pkg::sel_down, vip_pkg::coord_t'(down));
		write_reg(vip_pkg::sel_left, vip_pkg::coord_t'(left));
		write_reg(vip_pkg::sel_right, vip_pkg::coord_t'(right));
		write_reg(vip_pkg::sel_ctrl, {7'd0, en});
		@(negedge clk);
		capture_start = 1'b1;
		capture_open  = 1'b1;
		@(negedge clk);
		capture_start = 1'b0;
		n_writes = 0;
		got_done = 1'b0;
		while (!got_done) begin
			@(negedge clk);
			if (cap_we) begin
				if (n_writes >= n_pixels)
					stop_with("capture wrote more pixels than one frame holds");
				check_addr("cap_addr", vip_pkg::addr_t'(n_writes), cap_addr);
				check_pix("cap_data",
					expected_pixel(n_writes, up, down, left, right, en), cap_data);
				n_writes++;
			end
			if (frame_done)
				got_done = 1'b1;
		end
		capture_open = 1'b0;
		if (n_writes != n_pixels)
			stop_with($sformatf("frame closed after %0d writes instead of %0d",
				n_writes, n_pixels));
		// done is a single clock pulse
		@(negedge clk);
		if (frame_done !== 1'b0)
			stop_with("frame_done stayed high for more than one clock");
	endtask

	// ----------------------------------------------------------------------
	// monitors
	// ----------------------------------------------------------------------

	// write strobe only between arm and frame_done
	always @(negedge clk) begin
		if (rst_n === 1'b1 && !capture_open && cap_we !== 1'b0)
			stop_with("cap_we seen while no capture was armed");
	end

	// frame and line timing on the top-level sync outputs
	always @(negedge clk) begin
		if (rst_n === 1'b1) begin
			frame_len++;
			if (vsync === 1'b0)
				vs_low_len++;
			if (href === 1'b1)
				href_len++;
			if (href_q === 1'b1 && href === 1'b0) begin
				check_count("href high clocks", vip_pkg::img_hdisp * 2, href_len);
				href_len = 0;
				href_lines++;
			end
			if (vsync_q === 1'b0 && vsync === 1'b1) begin
				// first rise after reset only opens the count
				if (sync_locked) begin
					check_count("vsync period clocks", vip_pkg::frame_cycles, frame_len);
					check_count("vsync low clocks",
						vip_pkg::v_sync * vip_pkg::h_total * 2, vs_low_len);
					check_count("href lines per frame", vip_pkg::img_vdisp, href_lines);
					frames_checked++;
				end
				sync_locked = 1'b1;
				frame_len   = 0;
				vs_low_len  = 0;
				href_lines  = 0;
			end
			vsync_q = vsync;
			href_q  = href;
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout, run went past %0d cycles without finishing", cycle_limit);
			end_failed();
		end
	end

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		rst_n          = 1'b0;
		cfg_we         = 1'b0;
		cfg_sel        = vip_pkg::sel_up;
		cfg_wdata      = '0;
		capture_start  = 1'b0;
		capture_open   = 1'b0;
		cycle_count    = 0;
		cycle_limit    = 0;
		vsync_q        = 1'b0;
		href_q         = 1'b0;
		sync_locked    = 1'b0;
		frame_len      = 0;
		vs_low_len     = 0;
		href_len       = 0;
		href_lines     = 0;
		frames_checked = 0;
		seed_val = 32'h6b28_37e1;
		seed_val = $urandom(seed_val);
		for (int i = 0; i < n_pixels; i++)
			image_mem[i] = vip_pkg::pix_t'($urandom());
		$readmemh("tb/frame_cases.txt", case_words);
		n_cases = 0;
		while (n_cases < max_cases && !$isunknown(case_words[n_cases*case_fields]))
			n_cases++;
		if (n_cases == 0)
			stop_with("no cases read from tb/frame_cases.txt");
		cycle_limit = n_cases * 3 * vip_pkg::frame_cycles + 100;

		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// idle frame with nothing armed
		repeat (vip_pkg::frame_cycles) begin
			@(negedge clk);
			if (cap_we !== 1'b0 || frame_done !== 1'b0)
				stop_with("capture output active before any arm pulse");
		end

		for (int c = 0; c < n_cases; c++)
			run_case(c);

		// quiet after the last frame
		repeat (vip_pkg::frame_cycles) @(negedge clk);

		if (frames_checked == 0)
			stop_with("no complete vsync frame was observed");
		else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/frame_cases.txt */
// columns: up down left right overlay_en, all hex
// one frame capture per line
00 07 00 0f 0
02 05 03 0b 1
00 07 00 0f 1
01 01 04 09 1
03 06 0e 0e 1
04 02 05 08 1

/* tb.f */
verilog/vip_pkg.sv
verilog/cmos_timing_gen.sv
verilog/plate_box_regs.sv
verilog/box_overlay.sv
verilog/frame_capture.sv
verilog/cam_replay_top.sv
tb/cam_replay_chk.sv
tb/tb_cam_replay.sv

/* Bender.yml */
package:
  name: cam_replay

sources:
  - verilog/vip_pkg.sv
  - verilog/cmos_timing_gen.sv
  - verilog/plate_box_regs.sv
  - verilog/box_overlay.sv
  - verilog/frame_capture.sv
  - verilog/cam_replay_top.sv
  - target: simulation
    files:
      - tb/cam_replay_chk.sv
      - tb/tb_cam_replay.sv
